//--- src/ec_settings.svh
`ifndef EC_SETTINGS_SVH
`define EC_SETTINGS_SVH

// Lane geometry and datapath widths
`define EC_CHANNEL_WIDTH 8      // Lanes per word with lane 0 first in time
`define EC_ERR_WIDTH     10     // Signed residual error width
`define EC_EST_WIDTH     8      // Signed channel tap width
`define EC_EST_DEPTH     4      // Taps with tap 0 as the main cursor
`define EC_SHIFT_WIDTH   3      // Right shift applied to each correction term

// Flip patterns where pattern p sits at bits [3p+2:3p]
`define EC_NUM_PATTERNS  4
`define EC_PATTERN_DEPTH 3
`define EC_FLAG_WIDTH    3      // Holds flag values 0 to 4
`define EC_FLIP_PATTERNS 12'b101_111_011_010  // Bit j flips the lane j after the flag

// APB byte addresses
`define EC_ADDR_CTRL  8'h00     // Bit 0 is the correction enable
`define EC_ADDR_TAP0  8'h04
`define EC_ADDR_TAP1  8'h08
`define EC_ADDR_TAP2  8'h0C
`define EC_ADDR_TAP3  8'h10
`define EC_ADDR_SHIFT 8'h14

`endif

//--- src/ec_pkg.sv
`include "ec_settings.svh"

package ec_pkg;

    typedef logic signed [`EC_ERR_WIDTH-1:0] err_t;   // Elements stay signed when indexed
    typedef logic signed [`EC_EST_WIDTH-1:0] tap_t;
    typedef logic [`EC_FLAG_WIDTH-1:0] flag_t;

    // Input word straight from the slicer
    typedef struct packed {
        logic [`EC_CHANNEL_WIDTH-1:0]        bits;
        err_t [`EC_CHANNEL_WIDTH-1:0]        errors;
        flag_t [`EC_CHANNEL_WIDTH-1:0]       flags;
    } stream_word_t;

    typedef struct packed {
        logic [`EC_CHANNEL_WIDTH-1:0]        bits;
        err_t [`EC_CHANNEL_WIDTH-1:0]        errors;
    } lane_word_t;

    typedef struct packed {
        logic [`EC_CHANNEL_WIDTH-1:0]        bits;
        err_t [`EC_CHANNEL_WIDTH-1:0]        errors;
        logic [`EC_CHANNEL_WIDTH-1:0]        flips;      // One marks a bit to invert
    } flip_word_t;

    typedef struct packed {
        tap_t [`EC_EST_DEPTH-1:0]            taps;
        logic [`EC_SHIFT_WIDTH-1:0]          shift;
    } channel_est_t;

    typedef struct packed {
        logic                                psel;
        logic                                penable;
        logic                                pwrite;
        logic [7:0]                          paddr;
        logic [31:0]                         pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0]                         prdata;
        logic                                pready;
        logic                                pslverr;
    } apb_rsp_t;

endpackage : ec_pkg

//--- src/ec_stage_reg.sv
`timescale 1ns/100ps

// One cycle pipeline register whose payload only moves on a valid word
module ec_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Payload holds its last value while idle
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule : ec_stage_reg

//--- src/flip_bit_locator.sv
`timescale 1ns/100ps
`include "ec_settings.svh"

module flip_bit_locator (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 correct_enable,
    input  logic                 in_valid,
    input  ec_pkg::stream_word_t in_word,
    output logic                 out_valid,
    output ec_pkg::flip_word_t   out_word
);
    import ec_pkg::*;

    localparam int lanes       = `EC_CHANNEL_WIDTH;
    localparam int depth       = `EC_PATTERN_DEPTH;
    localparam int spill_width = depth - 1;    // Pattern bits that can pass lane 7

    localparam logic [`EC_NUM_PATTERNS*depth-1:0] patterns = `EC_FLIP_PATTERNS;

    logic [lanes+spill_width-1:0] mask_ext;    // Mask over this word and its spill lanes
    logic [spill_width-1:0]       spill_q;     // Spill from the last valid word
    flip_word_t                   next_word;

    always_comb begin
        int p;

        p        = 0;
        mask_ext = '0;
        mask_ext[spill_width-1:0] = spill_q;   // Earlier spill lands on the first lanes

        for (int i = 0; i < lanes; i++) begin
            if (in_word.flags[i] != '0 && in_word.flags[i] <= `EC_NUM_PATTERNS) begin
                p = int'(in_word.flags[i]) - 1;
                for (int j = 0; j < depth; j++) begin
                    if (patterns[p*depth + j]) begin
                        mask_ext[i+j] = 1'b1;
                    end
                end
            end
        end

        // With correction off no bit is flagged and nothing spills
        if (!correct_enable) begin
            mask_ext = '0;
        end
    end

    always_comb begin
        next_word.bits   = in_word.bits;
        next_word.errors = in_word.errors;
        next_word.flips  = mask_ext[lanes-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spill_q <= '0;
        end else if (in_valid) begin
            spill_q <= mask_ext[lanes +: spill_width];   // Idle cycles keep the spill
        end
    end

    ec_stage_reg #(
        .payload_t (flip_word_t)
    ) u_stage_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (next_word),
        .out_valid (out_valid),
        .out_data  (out_word)
    );

endmodule : flip_bit_locator

//--- src/flip_bit_reflector.sv
`timescale 1ns/100ps
`include "ec_settings.svh"

module flip_bit_reflector (
    input  logic                 clk,
    input  logic                 rst,
    input  ec_pkg::channel_est_t channel_est,
    input  logic                 in_valid,
    input  ec_pkg::flip_word_t   in_word,
    output logic                 out_valid,
    output ec_pkg::lane_word_t   out_word
);
    import ec_pkg::*;

    localparam int lanes      = `EC_CHANNEL_WIDTH;
    localparam int tap_count  = `EC_EST_DEPTH;
    localparam int spill_n    = tap_count - 1;    // Lanes past the word that a tap can reach
    localparam int term_width = `EC_EST_WIDTH + 2;
    localparam int sum_width  = `EC_ERR_WIDTH + 4;

    typedef logic signed [term_width-1:0] term_t;
    typedef logic signed [sum_width-1:0]  sum_t;

    localparam sum_t err_max = sum_t'((1 << (`EC_ERR_WIDTH - 1)) - 1);
    localparam sum_t err_min = -err_max - sum_t'(1);

    term_t [tap_count-1:0]     dbl_tap;      // Twice each tap
    term_t [tap_count-1:0]     up_term;      // Correction for an old bit of 1
    term_t [tap_count-1:0]     down_term;    // Correction for an old bit of 0
    sum_t [lanes+spill_n-1:0]  acc;
    sum_t [spill_n-1:0]        spill_q;      // Pending corrections for the next valid word
    lane_word_t                next_word;

    // Each term is shifted on its own before it is summed
    always_comb begin
        for (int k = 0; k < tap_count; k++) begin
            dbl_tap[k]   = {channel_est.taps[k][`EC_EST_WIDTH-1], channel_est.taps[k], 1'b0};
            up_term[k]   = dbl_tap[k] >>> channel_est.shift;
            down_term[k] = (-dbl_tap[k]) >>> channel_est.shift;
        end
    end

    always_comb begin
        for (int p = 0; p < lanes; p++) begin
            acc[p] = sum_t'(in_word.errors[p]);
        end
        for (int p = lanes; p < lanes + spill_n; p++) begin
            acc[p] = '0;
        end
        for (int p = 0; p < spill_n; p++) begin
            acc[p] = acc[p] + spill_q[p];    // Corrections carried from the last word
        end

        // A flip at lane m reaches lanes m to m+3
        for (int m = 0; m < lanes; m++) begin
            if (in_word.flips[m]) begin
                for (int k = 0; k < tap_count; k++) begin
                    acc[m+k] = acc[m+k] + (in_word.bits[m] ? up_term[k] : down_term[k]);
                end
            end
        end
    end

    always_comb begin
        next_word.bits = in_word.bits ^ in_word.flips;
        for (int m = 0; m < lanes; m++) begin
            if (acc[m] > err_max) begin
                next_word.errors[m] = err_max[`EC_ERR_WIDTH-1:0];
            end else if (acc[m] < err_min) begin
                next_word.errors[m] = err_min[`EC_ERR_WIDTH-1:0];
            end else begin
                next_word.errors[m] = acc[m][`EC_ERR_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spill_q <= '0;
        end else if (in_valid) begin
            spill_q <= acc[lanes +: spill_n];
        end
    end

    ec_stage_reg #(
        .payload_t (lane_word_t)
    ) u_stage_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (next_word),
        .out_valid (out_valid),
        .out_data  (out_word)
    );

endmodule : flip_bit_reflector

//--- src/error_corrector_datapath.sv
`timescale 1ns/100ps

// Locator in the first cycle and reflector in the second
module error_corrector_datapath (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 correct_enable,
    input  ec_pkg::channel_est_t channel_est,
    input  logic                 in_valid,
    input  ec_pkg::stream_word_t in_word,
    output logic                 out_valid,
    output ec_pkg::lane_word_t   out_word
);
    import ec_pkg::*;

    logic       flip_valid;
    flip_word_t flip_word;    // Bits and errors with the flip mask attached

    flip_bit_locator u_locator (
        .clk            (clk),
        .rst            (rst),
        .correct_enable (correct_enable),
        .in_valid       (in_valid),
        .in_word        (in_word),
        .out_valid      (flip_valid),
        .out_word       (flip_word)
    );

    flip_bit_reflector u_reflector (
        .clk         (clk),
        .rst         (rst),
        .channel_est (channel_est),
        .in_valid    (flip_valid),
        .in_word     (flip_word),
        .out_valid   (out_valid),
        .out_word    (out_word)
    );

endmodule : error_corrector_datapath

//--- src/ec_config_regs.sv
`timescale 1ns/100ps
`include "ec_settings.svh"

module ec_config_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  ec_pkg::apb_req_t     apb_req,
    output ec_pkg::apb_rsp_t     apb_rsp,
    output logic                 correct_enable,
    output ec_pkg::channel_est_t channel_est
);
    import ec_pkg::*;

    localparam int est_width = `EC_EST_WIDTH;

    logic         setup_phase;
    logic         access_phase;
    logic         addr_hit;       // Address maps to a register
    logic [31:0]  rdata;
    logic [31:0]  prdata_q;
    logic         pslverr_q;
    logic         enable_q;
    channel_est_t est_q;

    assign setup_phase  = apb_req.psel && !apb_req.penable;
    assign access_phase = apb_req.psel && apb_req.penable;

    // Read mux with taps sign-extended to the bus width
    always_comb begin
        addr_hit = 1'b1;
        rdata    = '0;
        case (apb_req.paddr)
            `EC_ADDR_CTRL:  rdata = {31'd0, enable_q};
            `EC_ADDR_TAP0:  rdata = {{(32-est_width){est_q.taps[0][est_width-1]}}, est_q.taps[0]};
            `EC_ADDR_TAP1:  rdata = {{(32-est_width){est_q.taps[1][est_width-1]}}, est_q.taps[1]};
            `EC_ADDR_TAP2:  rdata = {{(32-est_width){est_q.taps[2][est_width-1]}}, est_q.taps[2]};
            `EC_ADDR_TAP3:  rdata = {{(32-est_width){est_q.taps[3][est_width-1]}}, est_q.taps[3]};
            `EC_ADDR_SHIFT: rdata = {{(32-`EC_SHIFT_WIDTH){1'b0}}, est_q.shift};
            default: begin
                addr_hit = 1'b0;
            end
        endcase
    end

    // Writes land at the end of the access cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            enable_q <= 1'b0;
            est_q    <= '0;
        end else if (access_phase && apb_req.pwrite) begin
            case (apb_req.paddr)
                `EC_ADDR_CTRL:  enable_q     <= apb_req.pwdata[0];
                `EC_ADDR_TAP0:  est_q.taps[0] <= apb_req.pwdata[est_width-1:0];
                `EC_ADDR_TAP1:  est_q.taps[1] <= apb_req.pwdata[est_width-1:0];
                `EC_ADDR_TAP2:  est_q.taps[2] <= apb_req.pwdata[est_width-1:0];
                `EC_ADDR_TAP3:  est_q.taps[3] <= apb_req.pwdata[est_width-1:0];
                `EC_ADDR_SHIFT: est_q.shift  <= apb_req.pwdata[`EC_SHIFT_WIDTH-1:0];
                default: ;                                   // Unmapped write is dropped
            endcase
        end
    end

    // Response is loaded in setup so it is stable for the whole access cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            prdata_q  <= '0;
            pslverr_q <= 1'b0;
        end else if (setup_phase) begin
            prdata_q  <= apb_req.pwrite ? 32'd0 : rdata;
            pslverr_q <= !addr_hit;
        end else begin
            prdata_q  <= '0;
            pslverr_q <= 1'b0;
        end
    end

    assign apb_rsp = '{prdata: prdata_q, pready: 1'b1, pslverr: pslverr_q};

    assign correct_enable = enable_q;
    assign channel_est    = est_q;

endmodule : ec_config_regs

//--- src/error_corrector_top.sv
`timescale 1ns/100ps

module error_corrector_top (
    input  logic                 clk,
    input  logic                 rst,
    input  ec_pkg::apb_req_t     apb_req,
    output ec_pkg::apb_rsp_t     apb_rsp,
    input  logic                 in_valid,
    input  ec_pkg::stream_word_t in_word,
    output logic                 out_valid,
    output ec_pkg::lane_word_t   out_word
);
    import ec_pkg::*;

    logic         correct_enable;
    channel_est_t channel_est;      // Taps and shift held by the register block

    ec_config_regs u_config_regs (
        .clk            (clk),
        .rst            (rst),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .correct_enable (correct_enable),
        .channel_est    (channel_est)
    );

    error_corrector_datapath u_datapath (
        .clk            (clk),
        .rst            (rst),
        .correct_enable (correct_enable),
        .channel_est    (channel_est),
        .in_valid       (in_valid),
        .in_word        (in_word),
        .out_valid      (out_valid),
        .out_word       (out_word)
    );

endmodule : error_corrector_top

//--- tests/ec_ref_model.svh
`ifndef EC_REF_MODEL_SVH
`define EC_REF_MODEL_SVH

logic [`EC_PATTERN_DEPTH-2:0] model_flip_spill;              // Flips owed to the next word
int                           model_err_spill [`EC_EST_DEPTH-1];

function automatic void model_reset();
    model_flip_spill = '0;
    for (int k = 0; k < `EC_EST_DEPTH - 1; k++) begin
        model_err_spill[k] = 0;
    end
endfunction

// Expected output for one valid word, advancing the spill state of both stages
function automatic lane_word_t model_word(input stream_word_t w);
    logic [`EC_NUM_PATTERNS*`EC_PATTERN_DEPTH-1:0] table_bits;
    logic [`EC_CHANNEL_WIDTH+`EC_PATTERN_DEPTH-2:0] mask;
    int         sum [`EC_CHANNEL_WIDTH+`EC_EST_DEPTH-1];
    int         pat;
    int         sym;
    int         limit;
    lane_word_t res;

    table_bits = `EC_FLIP_PATTERNS;
    limit      = (1 << (`EC_ERR_WIDTH - 1)) - 1;
    mask       = '0;
    if (cfg_enable) begin
        mask[`EC_PATTERN_DEPTH-2:0] = model_flip_spill;
        for (int i = 0; i < `EC_CHANNEL_WIDTH; i++) begin
            if (w.flags[i] != 0) begin
                pat = int'(w.flags[i]) - 1;
                for (int j = 0; j < `EC_PATTERN_DEPTH; j++) begin
                    if (table_bits[pat*`EC_PATTERN_DEPTH + j]) begin
                        mask[i+j] = 1'b1;
                    end
                end
            end
        end
    end
    model_flip_spill = mask[`EC_CHANNEL_WIDTH +: `EC_PATTERN_DEPTH-1];

    for (int m = 0; m < `EC_CHANNEL_WIDTH; m++) begin
        sum[m] = int'($signed(w.errors[m]));
    end
    for (int m = `EC_CHANNEL_WIDTH; m < `EC_CHANNEL_WIDTH + `EC_EST_DEPTH - 1; m++) begin
        sum[m] = 0;
    end
    for (int m = 0; m < `EC_EST_DEPTH - 1; m++) begin
        sum[m] = sum[m] + model_err_spill[m];
    end

    // Old symbol is +1 for a one and -1 for a zero
    for (int m = 0; m < `EC_CHANNEL_WIDTH; m++) begin
        if (mask[m]) begin
            sym = w.bits[m] ? 1 : -1;
            for (int k = 0; k < `EC_EST_DEPTH; k++) begin
                sum[m+k] = sum[m+k] + ((2 * sym * cfg_taps[k]) >>> cfg_shift);
            end
        end
    end

    res.bits = w.bits ^ mask[`EC_CHANNEL_WIDTH-1:0];
    for (int m = 0; m < `EC_CHANNEL_WIDTH; m++) begin
        if (sum[m] > limit) begin
            sum[m] = limit;
        end else if (sum[m] < -limit - 1) begin
            sum[m] = -limit - 1;
        end
        res.errors[m] = err_t'(sum[m]);
    end
    for (int k = 0; k < `EC_EST_DEPTH - 1; k++) begin
        model_err_spill[k] = sum[`EC_CHANNEL_WIDTH + k];
    end
    return res;
endfunction

`endif

//--- tests/ec_tb.sv
`timescale 1ns/100ps
`include "ec_settings.svh"

module ec_tb;
    import ec_pkg::*;

    localparam int num_random   = 100;     // Random words in each half of the random test
    localparam int apb_accesses = 37;
    localparam int stream_words = 17 + 2 * num_random;
    localparam int idle_cycles  = 40;      // Gaps and pipeline drains
    localparam int cycle_limit  = 2 + 2 * apb_accesses + stream_words + idle_cycles + 50;

    logic         clk;
    logic         rst;
    apb_req_t     apb_req;
    apb_rsp_t     apb_rsp;
    logic         in_valid;
    stream_word_t in_word;
    logic         out_valid;
    lane_word_t   out_word;

    lane_word_t   exp_q [$];     // Expected output words in order
    int           reg_errors;
    int           word_errors;
    int           timing_errors;
    int           cycle_count;
    logic         cfg_enable;    // Configuration as last written over APB
    int           cfg_taps [`EC_EST_DEPTH];
    int           cfg_shift;

    `include "ec_ref_model.svh"

    error_corrector_top DUT (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

    always begin
        #4 clk = ~clk;
    end

    assert property (@(posedge clk) disable iff (rst) in_valid |-> ##2 out_valid)
        else begin
            timing_errors++;
            $display("out_valid did not rise 2 cycles after in_valid");
        end

    assert property (@(posedge clk) disable iff (rst) out_valid |-> $past(in_valid, 2))
        else begin
            timing_errors++;
            $display("out_valid rose without an in_valid 2 cycles before");
        end

    always @(posedge clk) begin : check_output
        lane_word_t expected;
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                word_errors++;
                $display("An output word arrived when none was expected");
            end else begin
                expected = exp_q.pop_front();
                assert (out_word.bits == expected.bits) else begin
                    word_errors++;
                    $display("FAILED out_word.bits got %h expected %h",
                             out_word.bits, expected.bits);
                end
                assert (out_word.errors == expected.errors) else begin
                    word_errors++;
                    $display("FAILED out_word.errors got %h expected %h",
                             out_word.errors, expected.errors);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("The run hit its cycle limit before the tests finished");
            $display("test failed");
            $finish;
        end
    end

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        #3;                          // Middle of the access cycle
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        assert (apb_rsp.pready) else begin
            reg_errors++;
            $display("pready was low in an access cycle");
        end
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        slverr;
        apb_access(1'b1, addr, data, rdata, slverr);
        assert (!slverr) else begin
            reg_errors++;
            $display("Write to address %h returned an error response", addr);
        end
    endtask

    task automatic check_reg(input logic [7:0] addr, input logic [31:0] expected);
        logic [31:0] rdata;
        logic        slverr;
        apb_access(1'b0, addr, 32'd0, rdata, slverr);
        assert (rdata == expected) else begin
            reg_errors++;
            $display("FAILED prdata at %h got %h expected %h", addr, rdata, expected);
        end
        assert (!slverr) else begin
            reg_errors++;
            $display("Read of address %h returned an error response", addr);
        end
    endtask

    // Reads back every register against the values last written
    task automatic check_config();
        check_reg(`EC_ADDR_CTRL, 32'(cfg_enable));
        for (int k = 0; k < `EC_EST_DEPTH; k++) begin
            check_reg(8'(`EC_ADDR_TAP0 + 4 * k), 32'(cfg_taps[k]));   // Sign-extended taps
        end
        check_reg(`EC_ADDR_SHIFT, 32'(cfg_shift));
    endtask

    task automatic check_unmapped(input logic [7:0] addr);
        logic [31:0] rdata;
        logic        slverr;
        apb_access(1'b1, addr, 32'd0, rdata, slverr);    // Zero differs from every programmed value
        assert (slverr) else begin
            reg_errors++;
            $display("Write to unmapped address %h gave no pslverr", addr);
        end
        apb_access(1'b0, addr, 32'd0, rdata, slverr);
        assert (slverr) else begin
            reg_errors++;
            $display("Read of unmapped address %h gave no pslverr", addr);
        end
        assert (rdata == 32'd0) else begin
            reg_errors++;
            $display("FAILED prdata at %h got %h expected %h", addr, rdata, 32'd0);
        end
    endtask

    task automatic set_channel(input int t0, input int t1, input int t2, input int t3,
                               input int sh);
        cfg_taps[0] = t0;
        cfg_taps[1] = t1;
        cfg_taps[2] = t2;
        cfg_taps[3] = t3;
        cfg_shift   = sh;
        for (int k = 0; k < `EC_EST_DEPTH; k++) begin
            write_reg(8'(`EC_ADDR_TAP0 + 4 * k), 32'(cfg_taps[k]));
        end
        write_reg(`EC_ADDR_SHIFT, 32'(sh));
    endtask

    // Lane errors rise by 7 per lane, and a zero flag value leaves the word unflagged
    function automatic stream_word_t word_with_flag(input logic [7:0] bits, input int err,
                                                    input int lane, input int flag);
        stream_word_t w;
        w.bits  = bits;
        w.flags = '0;
        for (int i = 0; i < `EC_CHANNEL_WIDTH; i++) begin
            w.errors[i] = err_t'(err + 7 * i);
        end
        w.flags[lane] = flag_t'(flag);
        return w;
    endfunction

    task automatic send_word(input stream_word_t w);
        in_valid = 1'b1;
        in_word  = w;
        exp_q.push_back(model_word(w));
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic random_words(input int count);
        stream_word_t w;
        for (int n = 0; n < count; n++) begin
            w.bits = 8'($urandom);
            for (int i = 0; i < `EC_CHANNEL_WIDTH; i++) begin
                w.errors[i] = err_t'($urandom);
                w.flags[i]  = ($urandom_range(3, 0) == 0) ? flag_t'($urandom_range(4, 1)) : '0;
            end
            send_word(w);
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_word       = '0;
        apb_req       = '0;
        reg_errors    = 0;
        word_errors   = 0;
        timing_errors = 0;
        cycle_count   = 0;
        cfg_enable    = 1'b0;
        cfg_shift     = 0;
        for (int k = 0; k < `EC_EST_DEPTH; k++) begin
            cfg_taps[k] = 0;
        end
        model_reset();
        void'($urandom(32'h600));
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        write_reg(`EC_ADDR_CTRL, 32'd1);
        cfg_enable = 1'b1;
        set_channel(-3, 100, -128, 127, 5);
        check_config();
        check_unmapped(8'h20);
        check_config();

        for (int n = 0; n < 8; n++) begin
            send_word(word_with_flag(8'($urandom), int'($urandom_range(300, 0)) - 150, 0, 0));
        end
        drain();

        set_channel(20, -12, 6, -3, 1);
        send_word(word_with_flag(8'b1010_0110, 40, 2, 3));
        send_word(word_with_flag(8'b0101_1001, -30, 0, 0));
        send_word(word_with_flag(8'b1100_0011, 15, 0, 4));
        send_word(word_with_flag(8'b0011_1100, 0, 4, 1));
        drain();

        // Pattern 111 on lane 7 reaches two lanes of the word after the gap
        send_word(word_with_flag(8'b1000_0001, 25, 7, 3));
        idle(5);
        send_word(word_with_flag(8'b0110_0110, -20, 0, 0));
        drain();

        write_reg(`EC_ADDR_CTRL, 32'd0);
        cfg_enable = 1'b0;
        send_word(word_with_flag(8'b1111_0000, 60, 7, 3));
        send_word(word_with_flag(8'b0000_1111, -60, 3, 2));
        send_word(word_with_flag(8'b1001_0110, 5, 5, 4));
        drain();

        write_reg(`EC_ADDR_CTRL, 32'd1);
        cfg_enable = 1'b1;
        set_channel(127, -128, 127, -128, 0);
        random_words(num_random);
        drain();
        set_channel(-128, 127, -64, 127, 2);
        random_words(num_random);
        drain();

        $display("register errors %0d, word errors %0d, timing errors %0d",
                 reg_errors, word_errors, timing_errors);
        if (reg_errors + word_errors + timing_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : ec_tb

//--- files.f
+incdir+src
+incdir+tests
src/ec_pkg.sv
src/ec_stage_reg.sv
src/flip_bit_locator.sv
src/flip_bit_reflector.sv
src/error_corrector_datapath.sv
src/ec_config_regs.sv
src/error_corrector_top.sv
tests/ec_tb.sv
